// ==== rtl/simf_decode_pkg.sv ====
package simf_decode_pkg;

  localparam int ADDR_W   = 12;
  localparam int OPCODE_W = 32;
  localparam int FMT_W    = 8;  // Instruction bits 31:24
  localparam int OP_W     = 12; // Instruction bits 11:0

  localparam logic [FMT_W-1:0] FMT_VOP2  = 8'h01;
  localparam logic [FMT_W-1:0] FMT_VOP1  = 8'h02;
  localparam logic [FMT_W-1:0] FMT_VOPC  = 8'h04;
  localparam logic [FMT_W-1:0] FMT_VOP3A = 8'h08;

  localparam logic [OP_W-1:0] OP_ADD         = 12'h003;
  localparam logic [OP_W-1:0] OP_SUB         = 12'h004;
  localparam logic [OP_W-1:0] OP_SUBREV      = 12'h005;
  localparam logic [OP_W-1:0] OP_MUL         = 12'h008;
  localparam logic [OP_W-1:0] OP_VOP3_ADD    = 12'h103;
  localparam logic [OP_W-1:0] OP_VOP3_SUB    = 12'h104;
  localparam logic [OP_W-1:0] OP_VOP3_SUBREV = 12'h105;
  localparam logic [OP_W-1:0] OP_VOP3_MUL    = 12'h108;
  localparam logic [OP_W-1:0] OP_MAC         = 12'h01F;
  localparam logic [OP_W-1:0] OP_MADMK       = 12'h020;
  localparam logic [OP_W-1:0] OP_MAX         = 12'h010;
  localparam logic [OP_W-1:0] OP_MAD         = 12'h141;
  localparam logic [OP_W-1:0] OP_SQRT        = 12'h033;
  localparam logic [OP_W-1:0] OP_RCP         = 12'h02A;
  localparam logic [OP_W-1:0] CMP_LO_LAST    = 12'h006; // Low compares start at 000
  localparam logic [OP_W-1:0] CMP_HI_FIRST   = 12'h009;
  localparam logic [OP_W-1:0] CMP_HI_LAST    = 12'h00F;

  // Operand address map
  localparam logic [ADDR_W-1:0] ADDR_LITERAL = 12'h7FF;
  localparam logic [ADDR_W-1:0] ADDR_VCC_LO  = 12'hE01;
  localparam logic [ADDR_W-1:0] ADDR_VCC_HI  = 12'hE02;
  localparam logic [ADDR_W-1:0] ADDR_M0      = 12'hE04;
  localparam logic [ADDR_W-1:0] ADDR_EXEC_LO = 12'hE08;
  localparam logic [ADDR_W-1:0] ADDR_EXEC_HI = 12'hE10;
  localparam logic [ADDR_W-1:0] ADDR_VCCZ    = 12'hE20;
  localparam logic [ADDR_W-1:0] ADDR_EXECZ   = 12'hE40;
  localparam logic [ADDR_W-1:0] ADDR_SCC     = 12'hE80;
  localparam logic [1:0]        PFX_CONST    = 2'b00;  // Top bits of inline constants
  localparam logic [1:0]        PFX_VGPR     = 2'b10;
  localparam logic [2:0]        PFX_SGPR     = 3'b110;

  typedef enum logic [3:0] {
    SRC_LITERAL = 4'd0,
    SRC_CONST   = 4'd1,
    SRC_VGPR    = 4'd2,
    SRC_SGPR    = 4'd3,
    SRC_VCC_LO  = 4'd4,
    SRC_VCC_HI  = 4'd5,
    SRC_M0      = 4'd6,
    SRC_EXEC_LO = 4'd7,
    SRC_EXEC_HI = 4'd8,
    SRC_VCCZ    = 4'd9,
    SRC_EXECZ   = 4'd10,
    SRC_SCC     = 4'd11,
    SRC_NONE    = 4'd15
  } src_sel_e;

  typedef struct packed {
    src_sel_e sel;
    logic     vgpr_rd_en;
  } src_decode_t;

  typedef struct packed {
    logic vcc;
    logic vgpr;
    logic sgpr;
  } wr_en_t;

  localparam src_decode_t SRC_DEC_IDLE = '{sel: SRC_NONE, vgpr_rd_en: 1'b0};
  localparam wr_en_t      WR_EN_NONE   = '{vcc: 1'b0, vgpr: 1'b0, sgpr: 1'b0};

endpackage

// ==== rtl/simf_src_decode.sv ====
module simf_src_decode
  import simf_decode_pkg::*;
(
  input  logic [ADDR_W-1:0] addr,
  output src_decode_t       dec
);

  logic [1:0] top2;
  logic [2:0] top3;

  assign top2 = addr[ADDR_W-1 -: 2];
  assign top3 = addr[ADDR_W-1 -: 3];

  always_comb
  begin
    dec.sel = SRC_NONE;
    if (addr == ADDR_LITERAL)
    begin
      dec.sel = SRC_LITERAL; // Checked before the range matches
    end
    else if (top2 == PFX_CONST)
    begin
      dec.sel = SRC_CONST;
    end
    else if (top2 == PFX_VGPR)
    begin
      dec.sel = SRC_VGPR;
    end
    else if (top3 == PFX_SGPR)
    begin
      dec.sel = SRC_SGPR;
    end
    else
    begin
      // One-hot special registers in the 111 range
      case (addr)
        ADDR_VCC_LO:  dec.sel = SRC_VCC_LO;
        ADDR_VCC_HI:  dec.sel = SRC_VCC_HI;
        ADDR_M0:      dec.sel = SRC_M0;
        ADDR_EXEC_LO: dec.sel = SRC_EXEC_LO;
        ADDR_EXEC_HI: dec.sel = SRC_EXEC_HI;
        ADDR_VCCZ:    dec.sel = SRC_VCCZ;
        ADDR_EXECZ:   dec.sel = SRC_EXECZ;
        ADDR_SCC:     dec.sel = SRC_SCC;
        default:      dec.sel = SRC_NONE; // Unmapped address
      endcase
    end
    dec.vgpr_rd_en = (dec.sel == SRC_VGPR);
  end

endmodule

// ==== rtl/simf_opcode_decode.sv ====
module simf_opcode_decode
  import simf_decode_pkg::*;
(
  input  logic [OPCODE_W-1:0] opcode,
  input  logic [ADDR_W-1:0]   sgpr_dest_addr,
  output wr_en_t              wr_en
);

  localparam wr_en_t WR_VGPR     = '{vcc: 1'b0, vgpr: 1'b1, sgpr: 1'b0};
  localparam wr_en_t WR_VCC      = '{vcc: 1'b1, vgpr: 1'b0, sgpr: 1'b0};
  localparam wr_en_t WR_VCC_SGPR = '{vcc: 1'b1, vgpr: 1'b0, sgpr: 1'b1};

  logic [FMT_W-1:0] fmt;
  logic [OP_W-1:0]  op;
  logic             op_is_cmp;
  wr_en_t           base;

  assign fmt = opcode[OPCODE_W-1 -: FMT_W];
  assign op  = opcode[OP_W-1:0]; // Bits 23:12 carry no decode info

  // Compare windows shared by VOPC and VOP3A
  assign op_is_cmp = (op <= CMP_LO_LAST) ||
                     ((op >= CMP_HI_FIRST) && (op <= CMP_HI_LAST));

  always_comb
  begin
    base = WR_EN_NONE;
    case (fmt)
      FMT_VOP2:
      begin
        case (op)
          OP_ADD, OP_SUB, OP_SUBREV, OP_MUL,
          OP_MAC, OP_MADMK, OP_MAX:
            base = WR_VGPR;
          default:
            base = WR_EN_NONE;
        endcase
      end
      FMT_VOP1:
      begin
        case (op)
          OP_SQRT, OP_RCP: base = WR_VGPR;
          default:         base = WR_EN_NONE;
        endcase
      end
      FMT_VOPC:
      begin
        if (op_is_cmp)
        begin
          base = WR_VCC;
        end
      end
      FMT_VOP3A:
      begin
        if (op_is_cmp)
        begin
          base = WR_VCC_SGPR; // Result lands in vcc and an SGPR pair
        end
        else
        begin
          case (op)
            OP_VOP3_ADD, OP_VOP3_SUB, OP_VOP3_SUBREV,
            OP_VOP3_MUL, OP_MAD:
              base = WR_VGPR;
            default:
              base = WR_EN_NONE;
          endcase
        end
      end
      default:
      begin
        base = WR_EN_NONE; // Unknown format writes nothing
      end
    endcase
  end

  // VOP3A destination steers vcc versus scalar write
  always_comb
  begin
    wr_en = base;
    if (fmt == FMT_VOP3A)
    begin
      if (sgpr_dest_addr == ADDR_VCC_LO)
      begin
        wr_en.vcc  = 1'b1;
        wr_en.sgpr = 1'b0;
      end
      else if (sgpr_dest_addr[ADDR_W-1 -: 3] == PFX_SGPR)
      begin
        wr_en.vcc  = 1'b0;
        wr_en.sgpr = 1'b1;
      end
    end
  end

endmodule

// ==== rtl/simf_instr_decoder.sv ====
module simf_instr_decoder
  import simf_decode_pkg::*;
(
  input  logic                clk,
  input  logic                arst_n,
  input  logic [OPCODE_W-1:0] opcode,
  input  logic [ADDR_W-1:0]   src1_addr,
  input  logic [ADDR_W-1:0]   src2_addr,
  input  logic [ADDR_W-1:0]   src3_addr,
  input  logic [ADDR_W-1:0]   sgpr_dest_addr,
  output wr_en_t              wr_en,
  output src_decode_t         src1_dec,
  output src_decode_t         src2_dec,
  output src_decode_t         src3_dec
);

  wr_en_t      wr_en_c;
  src_decode_t src1_dec_c;
  src_decode_t src2_dec_c;
  src_decode_t src3_dec_c;

  simf_opcode_decode opcode_dec_i (
    .opcode         (opcode),
    .sgpr_dest_addr (sgpr_dest_addr),
    .wr_en          (wr_en_c)
  );

  simf_src_decode src1_i (
    .addr (src1_addr),
    .dec  (src1_dec_c)
  );

  simf_src_decode src2_i (
    .addr (src2_addr),
    .dec  (src2_dec_c)
  );

  simf_src_decode src3_i (
    .addr (src3_addr),
    .dec  (src3_dec_c)
  );

  // Decode-to-issue register with one cycle latency
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_en    <= WR_EN_NONE;
      src1_dec <= SRC_DEC_IDLE;
      src2_dec <= SRC_DEC_IDLE;
      src3_dec <= SRC_DEC_IDLE;
    end
    else
    begin
      wr_en    <= wr_en_c;
      src1_dec <= src1_dec_c;
      src2_dec <= src2_dec_c;
      src3_dec <= src3_dec_c;
    end
  end

endmodule

// ==== include/simf_tb_vectors.svh ====
`ifndef SIMF_TB_VECTORS_SVH
`define SIMF_TB_VECTORS_SVH

typedef struct packed {
  logic [OPCODE_W-1:0] opcode;
  logic [ADDR_W-1:0]   src1_addr;
  logic [ADDR_W-1:0]   src2_addr;
  logic [ADDR_W-1:0]   src3_addr;
  logic [ADDR_W-1:0]   dest_addr;
  wr_en_t              wr_en;
  src_decode_t         src1_dec;
  src_decode_t         src2_dec;
  src_decode_t         src3_dec;
} tb_vec_t;

// Expected source decodes
localparam src_decode_t D_LIT   = '{SRC_LITERAL, 1'b0};
localparam src_decode_t D_CONST = '{SRC_CONST, 1'b0};
localparam src_decode_t D_VGPR  = '{SRC_VGPR, 1'b1};
localparam src_decode_t D_SGPR  = '{SRC_SGPR, 1'b0};
localparam src_decode_t D_VCCL  = '{SRC_VCC_LO, 1'b0};
localparam src_decode_t D_VCCH  = '{SRC_VCC_HI, 1'b0};
localparam src_decode_t D_M0    = '{SRC_M0, 1'b0};
localparam src_decode_t D_EXECL = '{SRC_EXEC_LO, 1'b0};
localparam src_decode_t D_EXECH = '{SRC_EXEC_HI, 1'b0};
localparam src_decode_t D_VCCZ  = '{SRC_VCCZ, 1'b0};
localparam src_decode_t D_EXECZ = '{SRC_EXECZ, 1'b0};
localparam src_decode_t D_SCC   = '{SRC_SCC, 1'b0};
localparam src_decode_t D_NONE  = '{SRC_NONE, 1'b0};

localparam int TB_NUM_VECS = 50;

// Wr_en columns are {vcc, vgpr, sgpr}
localparam tb_vec_t TB_VECS [TB_NUM_VECS] = '{
  '{32'h01_5a3_003, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h01_0f1_004, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h01_e27_005, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h01_3b4_008, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h01_902_01f, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h01_6c8_020, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h01_d11_010, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h01_4a0_006, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b000, D_CONST, D_VGPR, D_SGPR},
  '{32'h02_a5e_033, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h02_07c_02a, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h02_f33_003, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b000, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_2d9_103, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_b61_104, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_58e_105, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_c04_108, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_1ff_141, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h04_7a2_000, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b100, D_CONST, D_VGPR, D_SGPR},
  '{32'h04_e0b_006, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b100, D_CONST, D_VGPR, D_SGPR},
  '{32'h04_34d_009, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b100, D_CONST, D_VGPR, D_SGPR},
  '{32'h04_9f6_00f, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b100, D_CONST, D_VGPR, D_SGPR},
  '{32'h04_215_007, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b000, D_CONST, D_VGPR, D_SGPR},
  '{32'h04_ab3_010, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b000, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_6e1_000, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b101, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_0c7_006, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b101, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_d2a_009, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b101, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_83f_00f, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b101, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_f50_008, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b000, D_CONST, D_VGPR, D_SGPR},
  '{32'h10_a99_003, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b000, D_CONST, D_VGPR, D_SGPR},
  '{32'h00_12c_003, 12'h100, 12'h800, 12'hc05, 12'h000, 3'b000, D_CONST, D_VGPR, D_SGPR},
  // VOP3A destination override and formats that ignore the destination
  '{32'h08_e4d_103, 12'h100, 12'h800, 12'hc05, 12'he01, 3'b110, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_71b_103, 12'h100, 12'h800, 12'hc05, 12'hc10, 3'b011, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_b08_001, 12'h100, 12'h800, 12'hc05, 12'he01, 3'b100, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_3c6_001, 12'h100, 12'h800, 12'hc05, 12'hc20, 3'b001, D_CONST, D_VGPR, D_SGPR},
  '{32'h08_5d2_3ff, 12'h100, 12'h800, 12'hc05, 12'he01, 3'b100, D_CONST, D_VGPR, D_SGPR},
  '{32'h01_9e4_003, 12'h100, 12'h800, 12'hc05, 12'he01, 3'b010, D_CONST, D_VGPR, D_SGPR},
  '{32'h04_2f7_001, 12'h100, 12'h800, 12'hc05, 12'hc10, 3'b100, D_CONST, D_VGPR, D_SGPR},
  // Source classes rotated over all three operands
  '{32'h00_000_000, 12'h7ff, 12'h000, 12'h8ff, 12'h000, 3'b000, D_LIT, D_CONST, D_VGPR},
  '{32'h00_000_000, 12'hc00, 12'he01, 12'he02, 12'h000, 3'b000, D_SGPR, D_VCCL, D_VCCH},
  '{32'h00_000_000, 12'he04, 12'he08, 12'he10, 12'h000, 3'b000, D_M0, D_EXECL, D_EXECH},
  '{32'h00_000_000, 12'he20, 12'he40, 12'he80, 12'h000, 3'b000, D_VCCZ, D_EXECZ, D_SCC},
  '{32'h00_000_000, 12'hbff, 12'h7ff, 12'h3ff, 12'h000, 3'b000, D_VGPR, D_LIT, D_CONST},
  '{32'h00_000_000, 12'he02, 12'hdff, 12'he01, 12'h000, 3'b000, D_VCCH, D_SGPR, D_VCCL},
  '{32'h00_000_000, 12'he10, 12'he04, 12'he08, 12'h000, 3'b000, D_EXECH, D_M0, D_EXECL},
  '{32'h00_000_000, 12'he80, 12'he20, 12'he40, 12'h000, 3'b000, D_SCC, D_VCCZ, D_EXECZ},
  '{32'h00_000_000, 12'h2a5, 12'h9c3, 12'h7ff, 12'h000, 3'b000, D_CONST, D_VGPR, D_LIT},
  '{32'h00_000_000, 12'he01, 12'he02, 12'hd40, 12'h000, 3'b000, D_VCCL, D_VCCH, D_SGPR},
  '{32'h00_000_000, 12'he08, 12'he10, 12'he04, 12'h000, 3'b000, D_EXECL, D_EXECH, D_M0},
  '{32'h00_000_000, 12'he40, 12'he80, 12'he20, 12'h000, 3'b000, D_EXECZ, D_SCC, D_VCCZ},
  '{32'h00_000_000, 12'h5ab, 12'he81, 12'hf00, 12'h000, 3'b000, D_NONE, D_NONE, D_NONE},
  '{32'h00_000_000, 12'he00, 12'h5ab, 12'h400, 12'h000, 3'b000, D_NONE, D_NONE, D_NONE}
};

`endif

// ==== dv/simf_instr_decoder_tb.sv ====
module simf_instr_decoder_tb
  import simf_decode_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

`include "simf_tb_vectors.svh"

  localparam logic [31:0] SEED        = 32'hc7d2_1805;
  localparam int          NUM_RANDOM  = 200;
  localparam int          WAIT_LIMIT  = 8;       // Cycles allowed for any wait loop
  localparam int          WATCHDOG_NS = 100_000;

  localparam logic [FMT_W-1:0] FMT_POOL [4] = '{FMT_VOP2, FMT_VOP1, FMT_VOPC, FMT_VOP3A};
  localparam logic [OP_W-1:0]  OP_POOL [16] = '{
    OP_ADD, OP_SUB, OP_SUBREV, OP_MUL, OP_VOP3_ADD, OP_VOP3_SUB, OP_VOP3_SUBREV, OP_VOP3_MUL,
    OP_MAC, OP_MADMK, OP_MAX, OP_MAD, OP_SQRT, OP_RCP, 12'h007, 12'h00C
  };
  localparam logic [ADDR_W-1:0] SPECIAL_POOL [8] = '{
    ADDR_VCC_LO, ADDR_VCC_HI, ADDR_M0, ADDR_EXEC_LO,
    ADDR_EXEC_HI, ADDR_VCCZ, ADDR_EXECZ, ADDR_SCC
  };

  logic                clk;
  logic                arst_n;
  logic [OPCODE_W-1:0] opcode;
  logic [ADDR_W-1:0]   src1_addr;
  logic [ADDR_W-1:0]   src2_addr;
  logic [ADDR_W-1:0]   src3_addr;
  logic [ADDR_W-1:0]   sgpr_dest_addr;
  wr_en_t              wr_en;
  src_decode_t         src1_dec;
  src_decode_t         src2_dec;
  src_decode_t         src3_dec;

  int          err_count;
  int          check_count;
  int          test_count;
  int          fail_count;
  logic [31:0] rng_state;
  tb_vec_t     pend_vec;   // Item in flight until its check one cycle later
  string       pend_tag;
  logic        pend_valid;
  tb_vec_t     quiet_vec;

  simf_instr_decoder dut_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .opcode         (opcode),
    .src1_addr      (src1_addr),
    .src2_addr      (src2_addr),
    .src3_addr      (src3_addr),
    .sgpr_dest_addr (sgpr_dest_addr),
    .wr_en          (wr_en),
    .src1_dec       (src1_dec),
    .src2_dec       (src2_dec),
    .src3_dec       (src3_dec)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // Expected operand decode by address range
  function automatic src_decode_t ref_src(input logic [ADDR_W-1:0] a);
    src_decode_t d;
    d.sel        = SRC_NONE;
    d.vgpr_rd_en = 1'b0;
    if (a == ADDR_LITERAL)
      d.sel = SRC_LITERAL;
    else if (a < 12'h400)
      d.sel = SRC_CONST;
    else if (a >= 12'h800 && a < 12'hC00)
    begin
      d.sel        = SRC_VGPR;
      d.vgpr_rd_en = 1'b1;
    end
    else if (a >= 12'hC00 && a < 12'hE00)
      d.sel = SRC_SGPR;
    else if (a == ADDR_VCC_LO)
      d.sel = SRC_VCC_LO;
    else if (a == ADDR_VCC_HI)
      d.sel = SRC_VCC_HI;
    else if (a == ADDR_M0)
      d.sel = SRC_M0;
    else if (a == ADDR_EXEC_LO)
      d.sel = SRC_EXEC_LO;
    else if (a == ADDR_EXEC_HI)
      d.sel = SRC_EXEC_HI;
    else if (a == ADDR_VCCZ)
      d.sel = SRC_VCCZ;
    else if (a == ADDR_EXECZ)
      d.sel = SRC_EXECZ;
    else if (a == ADDR_SCC)
      d.sel = SRC_SCC;
    return d;
  endfunction

  function automatic wr_en_t ref_wr_en(input logic [OPCODE_W-1:0] word,
                                       input logic [ADDR_W-1:0] dest);
    logic [FMT_W-1:0] f;
    logic [OP_W-1:0]  n;
    logic             cmp;
    wr_en_t           w;
    f   = word[31:24];
    n   = word[11:0];
    cmp = n inside {[12'h000:12'h006], [12'h009:12'h00F]};
    w   = '{vcc: 1'b0, vgpr: 1'b0, sgpr: 1'b0};
    if (f == FMT_VOP2 && (n inside {OP_ADD, OP_SUB, OP_SUBREV, OP_MUL, OP_MAC, OP_MADMK, OP_MAX}))
      w.vgpr = 1'b1;
    if (f == FMT_VOP1 && (n inside {OP_SQRT, OP_RCP}))
      w.vgpr = 1'b1;
    if (f == FMT_VOPC && cmp)
      w.vcc = 1'b1;
    if (f == FMT_VOP3A)
    begin
      w.vcc  = cmp;
      w.sgpr = cmp;
      w.vgpr = n inside {OP_VOP3_ADD, OP_VOP3_SUB, OP_VOP3_SUBREV, OP_VOP3_MUL, OP_MAD};
      if (dest == ADDR_VCC_LO)
      begin
        w.vcc  = 1'b1;
        w.sgpr = 1'b0;
      end
      else if (dest >= 12'hC00 && dest < 12'hE00)
      begin
        w.vcc  = 1'b0;
        w.sgpr = 1'b1;
      end
    end
    return w;
  endfunction

  function automatic tb_vec_t make_vec(input logic [OPCODE_W-1:0] word,
                                       input logic [ADDR_W-1:0] a1, a2, a3, dest);
    tb_vec_t v;
    v.opcode    = word;
    v.src1_addr = a1;
    v.src2_addr = a2;
    v.src3_addr = a3;
    v.dest_addr = dest;
    v.wr_en     = ref_wr_en(word, dest);
    v.src1_dec  = ref_src(a1);
    v.src2_dec  = ref_src(a2);
    v.src3_dec  = ref_src(a3);
    return v;
  endfunction

  // Biased toward literal and special addresses
  function automatic logic [ADDR_W-1:0] pick_addr(input logic [31:0] r);
    case (r[3:0])
      4'd0:       return ADDR_LITERAL;
      4'd1, 4'd2: return SPECIAL_POOL[r[6:4]];
      default:    return r[31:20];
    endcase
  endfunction

  task automatic random_vec(output tb_vec_t v);
    logic [31:0]      r1, r2, r3, r4, r5;
    logic [FMT_W-1:0] fmt;
    logic [OP_W-1:0]  op;
    logic [ADDR_W-1:0] dest;
    next_random(r1);
    next_random(r2);
    next_random(r3);
    next_random(r4);
    next_random(r5);
    fmt = (r2[3:2] == 2'b00) ? r2[31:24] : FMT_POOL[r2[1:0]];
    op  = r2[4] ? {3'b000, r2[16:8]} : OP_POOL[r2[23:20]];
    case (r3[21:20])
      2'd0:    dest = ADDR_VCC_LO;
      2'd1:    dest = {3'b110, r3[30:22]};
      default: dest = r3[31:20];
    endcase
    v = make_vec({fmt, r3[11:0], op}, pick_addr(r1), pick_addr(r4), pick_addr(r5), dest);
  endtask

  task automatic drive(input tb_vec_t v);
    opcode         <= v.opcode;
    src1_addr      <= v.src1_addr;
    src2_addr      <= v.src2_addr;
    src3_addr      <= v.src3_addr;
    sgpr_dest_addr <= v.dest_addr;
  endtask

  task automatic check_wr_en(input string what, input wr_en_t got, input wr_en_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("Mismatch at %0t: %s wr_en {vcc,vgpr,sgpr} got %b%b%b, expected %b%b%b",
               $time, what, got.vcc, got.vgpr, got.sgpr, exp.vcc, exp.vgpr, exp.sgpr);
    end
  endtask

  task automatic check_src(input string what, input src_decode_t got, input src_decode_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("Mismatch at %0t: %s got sel=%0d rd_en=%b, expected sel=%0d rd_en=%b",
               $time, what, got.sel, got.vgpr_rd_en, exp.sel, exp.vgpr_rd_en);
    end
  endtask

  task automatic check_outputs(input tb_vec_t e, input string tag);
    check_wr_en(tag, wr_en, e.wr_en);
    check_src({tag, " src1"}, src1_dec, e.src1_dec);
    check_src({tag, " src2"}, src2_dec, e.src2_dec);
    check_src({tag, " src3"}, src3_dec, e.src3_dec);
  endtask

  task automatic check_idle(input string tag);
    check_wr_en(tag, wr_en, 3'b000);
    check_src({tag, " src1"}, src1_dec, D_NONE);
    check_src({tag, " src2"}, src2_dec, D_NONE);
    check_src({tag, " src3"}, src3_dec, D_NONE);
  endtask

  function automatic logic outputs_quiet();
    return wr_en === 3'b000 && src1_dec === D_NONE &&
           src2_dec === D_NONE && src3_dec === D_NONE;
  endfunction

  // Drive on the rising edge and check the previous item at the falling edge
  task automatic issue(input tb_vec_t v, input string tag);
    @(posedge clk);
    drive(v);
    @(negedge clk);
    if (pend_valid)
      check_outputs(pend_vec, pend_tag);
    pend_vec   = v;
    pend_tag   = tag;
    pend_valid = 1'b1;
  endtask

  task automatic end_stream(input string name);
    int n;
    issue(quiet_vec, "quiet");
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (!outputs_quiet() && n < WAIT_LIMIT);
    if (!outputs_quiet())
    begin
      err_count++;
      $display("Timeout: outputs did not return to idle within %0d cycles after %s",
               WAIT_LIMIT, name);
    end
    pend_valid = 1'b0;
  endtask

  task automatic finish_test(input string name, input int err_start);
    test_count++;
    if (err_count != err_start)
    begin
      fail_count++;
      $display("[FAIL] %s: %0d errors", name, err_count - err_start);
    end
    else
      $display("[ ok ] %s", name);
  endtask

  task automatic run_rows(input int first, input int last, input string name);
    int err_start;
    err_start = err_count;
    for (int i = first; i <= last; i++)
      issue(TB_VECS[i], $sformatf("table row %0d", i));
    end_stream(name);
    finish_test(name, err_start);
  endtask

  initial
  begin
    int      err_start;
    tb_vec_t v;
    tb_vec_t tp [3];
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    fail_count  = 0;
    rng_state   = SEED;
    pend_valid  = 1'b0;
    quiet_vec   = make_vec(32'h0000_0000, 12'h5AB, 12'h5AB, 12'h5AB, 12'h000);
    arst_n <= 1'b0;
    drive(make_vec({FMT_VOP2, 12'h000, OP_ADD}, 12'h800, 12'h800, 12'h800, 12'hC00));

    err_start = err_count;
    repeat (2)
    begin
      @(negedge clk);
      check_idle("during reset");
      @(posedge clk);
    end
    arst_n <= 1'b1;
    @(negedge clk);
    check_idle("after reset release"); // Before the first sampling edge
    finish_test("reset", err_start);

    run_rows(0, 28, "opcode table");
    run_rows(29, 35, "VOP3A destination override");
    run_rows(36, TB_NUM_VECS - 1, "source classification");

    err_start = err_count;
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      random_vec(v);
      issue(v, $sformatf("random %0d", i));
    end
    end_stream("random sweep");
    finish_test("random sweep", err_start);

    // Outputs change every cycle
    tp[0] = make_vec({FMT_VOP2, 12'h3C5, OP_MUL}, 12'h8A0, ADDR_LITERAL, 12'hC33, 12'hC00);
    tp[1] = make_vec({FMT_VOP3A, 12'h0A1, 12'h00B}, ADDR_VCC_LO, 12'h001, ADDR_SCC, 12'hC40);
    tp[2] = make_vec({FMT_VOPC, 12'h7E2, 12'h002}, 12'h3F0, 12'hB00, ADDR_M0, 12'h000);
    err_start = err_count;
    for (int i = 0; i < 12; i++)
      issue(tp[i % 3], $sformatf("back-to-back %0d", i));
    end_stream("throughput");
    finish_test("throughput", err_start);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_count, fail_count, check_count, err_count);
    if (err_count == 0 && fail_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    #WATCHDOG_NS;
    $display("Timeout: simulation did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
rtl/simf_decode_pkg.sv
rtl/simf_src_decode.sv
rtl/simf_opcode_decode.sv
rtl/simf_instr_decoder.sv
dv/simf_instr_decoder_tb.sv

// ==== Makefile ====
TOP := simf_instr_decoder_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
